/* hdl/fb_types_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Fill buffer data widths, ECC word and row types,
// and the fill and store input structs
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package fb_types_pkg;

   localparam int FB_DATA_BITS   = 32;   // Data bits per ECC word
   localparam int FB_ECC_BITS    = 7;    // Check bits per ECC word
   localparam int FB_WORD_W      = FB_DATA_BITS + FB_ECC_BITS;
   localparam int FB_WORDS       = 16;   // Words in one array row
   localparam int FB_FILL_WORDS  = 4;    // Words in one DRAM fill beat
   localparam int FB_STORE_WORDS = 2;    // Words in one store
   localparam int FB_WL_W        = 3;    // Entry wordline width

   localparam int FB_FILL_W  = FB_FILL_WORDS * FB_WORD_W;   // 156
   localparam int FB_STORE_W = FB_STORE_WORDS * FB_WORD_W;  // 78

   // One ECC word, data on top and check bits below
   typedef struct packed {
      logic [FB_DATA_BITS-1:0] data;
      logic [FB_ECC_BITS-1:0]  ecc;
   } fb_word_t;

   // Full row of the array, word 15 in the upper bits
   typedef fb_word_t [FB_WORDS-1:0] fb_row_t;

   // DRAM fill side
   typedef struct packed {
      logic [FB_FILL_WORDS*FB_DATA_BITS-1:0] data;
      logic [FB_FILL_WORDS*FB_ECC_BITS-1:0]  ecc;
      logic [FB_WORDS-1:0]                   wen;  // One bit per row word
      logic [FB_WL_W-1:0]                    wl;   // Target entry
   } fb_fill_in_t;

   // Store side, data already carries its ECC
   typedef struct packed {
      logic [FB_STORE_W-1:0] stdecc;
      logic                  sel;   // High picks store data over fill
   } fb_store_in_t;

endpackage

`default_nettype wire

/* hdl/fb_ctrl_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Write source enum and the
// registered write control struct
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package fb_ctrl_pkg;

   import fb_types_pkg::*;

   // Which path feeds the array write row
   typedef enum logic {
      FB_SRC_FILL  = 1'b0,
      FB_SRC_STORE = 1'b1
   } fb_src_e;

   // Write control as seen by the array
   typedef struct packed {
      logic [FB_WORDS-1:0] wen;   // Per-word write enable
      logic [FB_WL_W-1:0]  wl;    // Entry to write
      fb_src_e             src;
   } fb_wr_ctrl_t;

endpackage

`default_nettype wire

/* hdl/fb_fill_stage.sv */
// ~~~~~~~~~~~~~~~~~~~~
// DRAM fill stage: interleaves data with check bits
// and registers words, wen and wordline (R2 to R3)
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ps

module fb_fill_stage
   import fb_types_pkg::*;
(
   input  logic                 rclk,
   input  logic                 rst,
   input  fb_fill_in_t          fill_in,
   output logic [FB_FILL_W-1:0] fill_words,
   output logic [FB_WORDS-1:0]  fill_ctrl_wen,
   output logic [FB_WL_W-1:0]   fill_ctrl_wl
);

   fb_word_t [FB_FILL_WORDS-1:0] fill_mix;   // Interleaved R2 words

   // Word k takes data quarter k and check byte k
   always_comb begin
      for (int k = 0; k < FB_FILL_WORDS; k++) begin
         fill_mix[k].data = fill_in.data[FB_DATA_BITS*k +: FB_DATA_BITS];
         fill_mix[k].ecc  = fill_in.ecc[FB_ECC_BITS*k +: FB_ECC_BITS];
      end
   end

   // Write enable must come up clean after reset
   always_ff @(posedge rclk) begin
      if (rst) begin
         fill_ctrl_wen <= '0;
      end else begin
         fill_ctrl_wen <= fill_in.wen;
      end
   end

   // Payload and wordline only matter when wen is set
   always_ff @(posedge rclk) begin
      fill_words   <= fill_mix;
      fill_ctrl_wl <= fill_in.wl;
   end

endmodule

`default_nettype wire

/* hdl/fb_store_stage.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Store stage: registers ECC store data
// and the store select (C3 to C4)
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ps

module fb_store_stage
   import fb_types_pkg::*;
(
   input  logic                  rclk,
   input  logic                  rst,
   input  fb_store_in_t          store_in,
   output logic [FB_STORE_W-1:0] store_words,
   output logic                  store_sel
);

   // Select defaults to the fill path out of reset
   always_ff @(posedge rclk) begin
      if (rst) begin
         store_sel <= 1'b0;
      end else begin
         store_sel <= store_in.sel;
      end
   end

   always_ff @(posedge rclk) begin
      store_words <= store_in.stdecc;   // Two words, passed as is
   end

endmodule

`default_nettype wire

/* hdl/fb_data_array.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Fill buffer array: source select, row replication,
// per-word writes and a registered read port
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ps

module fb_data_array
   import fb_types_pkg::*;
   import fb_ctrl_pkg::*;
#(
   parameter int FB_ENTRIES = 8
) (
   input  logic                  rclk,
   input  logic                  rst,
   input  logic [FB_FILL_W-1:0]  fill_words,
   input  logic [FB_WORDS-1:0]   fill_wen,
   input  logic [FB_WL_W-1:0]    fill_wl,
   input  logic [FB_STORE_W-1:0] store_words,
   input  logic                  store_sel,
   input  logic                  rd_en,
   input  logic [FB_WL_W-1:0]    rd_wl,
   output fb_row_t               rd_data,
   output logic                  rd_valid
);

   fb_wr_ctrl_t wr_ctrl;
   fb_row_t     wr_row;     // Source replicated across the row

   fb_row_t     mem [FB_ENTRIES];

   // Fill and store share one wen and wordline
   always_comb begin
      wr_ctrl.wen = fill_wen;
      wr_ctrl.wl  = fill_wl;
      wr_ctrl.src = store_sel ? FB_SRC_STORE : FB_SRC_FILL;
   end

   // Word i of the row carries source word i mod 4 or i mod 2
   always_comb begin
      case (wr_ctrl.src)
         FB_SRC_STORE: wr_row = {(FB_WORDS/FB_STORE_WORDS){store_words}};
         default:      wr_row = {(FB_WORDS/FB_FILL_WORDS){fill_words}};
      endcase
   end

   always_ff @(posedge rclk) begin
      for (int i = 0; i < FB_WORDS; i++) begin
         if (wr_ctrl.wen[i]) begin
            mem[wr_ctrl.wl][i] <= wr_row[i];
         end
      end
   end

   // A read on the write edge still sees the old row
   always_ff @(posedge rclk) begin
      if (rd_en) begin
         rd_data <= mem[rd_wl];
      end
   end

   always_ff @(posedge rclk) begin
      if (rst) begin
         rd_valid <= 1'b0;
      end else begin
         rd_valid <= rd_en;   // One cycle read latency
      end
   end

endmodule

`default_nettype wire

/* hdl/fb_buf_top.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Fill buffer data path top: fill stage,
// store stage and the data array
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ps

module fb_buf_top
   import fb_types_pkg::*;
#(
   parameter int FB_ENTRIES = 8
) (
   input  logic               rclk,
   input  logic               rst,
   input  fb_fill_in_t        fill_in,
   input  fb_store_in_t       store_in,
   input  logic               rd_en,
   input  logic [FB_WL_W-1:0] rd_wl,
   output fb_row_t            rd_data,
   output logic               rd_valid
);

   logic [FB_FILL_W-1:0]  fill_words;
   logic [FB_WORDS-1:0]   fill_wen;
   logic [FB_WL_W-1:0]    fill_wl;
   logic [FB_STORE_W-1:0] store_words;
   logic                  store_sel;

   fb_fill_stage fill_stage_i (
      .rclk          (rclk),
      .rst           (rst),
      .fill_in       (fill_in),
      .fill_words    (fill_words),
      .fill_ctrl_wen (fill_wen),
      .fill_ctrl_wl  (fill_wl)
   );

   fb_store_stage store_stage_i (
      .rclk        (rclk),
      .rst         (rst),
      .store_in    (store_in),
      .store_words (store_words),
      .store_sel   (store_sel)
   );

   fb_data_array #(
      .FB_ENTRIES (FB_ENTRIES)
   ) data_array_i (
      .rclk        (rclk),
      .rst         (rst),
      .fill_words  (fill_words),
      .fill_wen    (fill_wen),
      .fill_wl     (fill_wl),
      .store_words (store_words),
      .store_sel   (store_sel),
      .rd_en       (rd_en),
      .rd_wl       (rd_wl),
      .rd_data     (rd_data),
      .rd_valid    (rd_valid)
   );

endmodule

`default_nettype wire

/* bench/fb_buf_asserts.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Concurrent checks on the array read and write timing,
// bound into every fb_data_array
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ps

module fb_buf_asserts
   import fb_types_pkg::*;
#(
   parameter int FB_ENTRIES = 8
) (
   input logic                rclk,
   input logic                rst,
   input logic [FB_WORDS-1:0] fill_wen,
   input logic [FB_WL_W-1:0]  fill_wl,
   input logic                rd_en,
   input logic                rd_valid
);

   // rd_valid is rd_en one clock later
   a_rd_valid_follows: assert property (
      @(posedge rclk) disable iff (rst)
      !$past(rst) |-> (rd_valid == $past(rd_en))
   ) else $error("rd_valid does not follow rd_en by one cycle");

   a_valid_low_after_reset: assert property (
      @(posedge rclk) $past(rst) |-> !rd_valid
   ) else $error("rd_valid high in the cycle after reset");

   // A live write must target an existing entry
   a_write_wl_in_range: assert property (
      @(posedge rclk) disable iff (rst)
      (|fill_wen) |-> (int'(fill_wl) < FB_ENTRIES)
   ) else $error("write to entry %0d beyond the array", fill_wl);

endmodule

bind fb_data_array fb_buf_asserts #(
   .FB_ENTRIES (FB_ENTRIES)
) asserts_i (
   .rclk     (rclk),
   .rst      (rst),
   .fill_wen (fill_wen),
   .fill_wl  (fill_wl),
   .rd_en    (rd_en),
   .rd_valid (rd_valid)
);

`default_nettype wire

/* bench/fb_buf_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Fill buffer testbench: step table, reference model
// of the array, compare tasks and a cycle timeout
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ps

module fb_buf_tb
   import fb_types_pkg::*;
();

   localparam int ENTRIES = 8;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_FILL,
      ST_STORE,
      ST_READ
   } step_kind_e;

   typedef struct packed {
      step_kind_e          kind;
      logic                sel;     // Store data picked for the write
      logic [FB_WORDS-1:0] wen;
      logic [FB_WL_W-1:0]  wl;
      logic [FB_WL_W-1:0]  rd_wl;
   } step_t;

   logic               rclk;
   logic               rst;
   fb_fill_in_t        fill_in;
   fb_store_in_t       store_in;
   logic               rd_en;
   logic [FB_WL_W-1:0] rd_wl;
   fb_row_t            rd_data;
   logic               rd_valid;

   step_t        steps [$];
   fb_row_t      model_mem [ENTRIES];
   fb_fill_in_t  drv_fill;     // What the DUT sees at the next edge
   fb_store_in_t drv_store;
   logic         drv_rd_en;
   logic [2:0]   drv_rd_wl;
   fb_fill_in_t  stg_fill;     // Stage registers, one edge behind
   fb_store_in_t stg_store;
   fb_row_t      exp_row;
   logic         exp_valid;
   logic         exp_row_known;
   logic [31:0]  lcg_state;
   int           cycle_count = 0;
   int           cycle_limit = 1000;

   fb_buf_top #(
      .FB_ENTRIES (ENTRIES)
   ) dut_i (
      .rclk     (rclk),
      .rst      (rst),
      .fill_in  (fill_in),
      .store_in (store_in),
      .rd_en    (rd_en),
      .rd_wl    (rd_wl),
      .rd_data  (rd_data),
      .rd_valid (rd_valid)
   );

   always #2 rclk = ~rclk;

   always @(posedge rclk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count > cycle_limit) begin
         $display("ERROR: run did not finish within %0d cycles", cycle_limit);
         $display("test failed");
         $fatal(1, "timeout");
      end
   end

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   // Row word i gets fill word i mod 4, data quarter over its check bits
   function automatic fb_row_t fill_row(input fb_fill_in_t f);
      fb_row_t row;
      int      k;
      for (int i = 0; i < FB_WORDS; i++) begin
         k = i % 4;
         row[i] = {f.data[32*k +: 32], f.ecc[7*k +: 7]};
      end
      return row;
   endfunction

   function automatic fb_row_t store_row(input fb_store_in_t s);
      fb_row_t row;
      for (int i = 0; i < FB_WORDS; i++) begin
         row[i] = s.stdecc[39*(i % 2) +: 39];   // Word i mod 2
      end
      return row;
   endfunction

   task automatic add_step(input step_kind_e kind, input logic [15:0] wen,
                           input logic [2:0] wl);
      step_t st;
      st.kind  = kind;
      st.sel   = (kind == ST_STORE);
      st.wen   = wen;
      st.wl    = wl;
      st.rd_wl = wl;
      steps.push_back(st);
   endtask

   task automatic build_table();
      int order [8] = '{5, 2, 7, 0, 3, 6, 1, 4};
      add_step(ST_IDLE, 16'h0000, 3'd0);
      add_step(ST_IDLE, 16'h0000, 3'd0);
      for (int e = 0; e < ENTRIES; e++) begin
         add_step(ST_FILL, 16'hFFFF, 3'(e));   // Full rows everywhere
      end
      add_step(ST_IDLE, 16'h0000, 3'd0);
      // Shuffled reads, each entry returns its own row
      for (int e = 0; e < 8; e++) begin
         add_step(ST_READ, 16'h0000, 3'(order[e]));
      end
      add_step(ST_STORE, 16'h30C5, 3'd2);       // Partial store
      add_step(ST_IDLE, 16'h0000, 3'd0);
      add_step(ST_READ, 16'h0000, 3'd2);
      // Sparse fill, first read lands on the write edge
      add_step(ST_FILL, 16'hA452, 3'd5);
      add_step(ST_READ, 16'h0000, 3'd5);
      add_step(ST_READ, 16'h0000, 3'd5);
      add_step(ST_FILL, 16'h0000, 3'd3);        // Zero enable
      add_step(ST_STORE, 16'h0000, 3'd4);
      add_step(ST_IDLE, 16'h0000, 3'd0);
      add_step(ST_READ, 16'h0000, 3'd3);
      add_step(ST_READ, 16'h0000, 3'd4);
      add_step(ST_STORE, 16'hFFFF, 3'd7);
      add_step(ST_FILL, 16'h0F0F, 3'd7);        // Back to back, same entry
      add_step(ST_IDLE, 16'h0000, 3'd0);
      add_step(ST_READ, 16'h0000, 3'd7);
      add_step(ST_FILL, 16'hFF00, 3'd1);
      add_step(ST_READ, 16'h0000, 3'd0);
      add_step(ST_READ, 16'h0000, 3'd1);
      add_step(ST_READ, 16'h0000, 3'd1);
      add_step(ST_IDLE, 16'h0000, 3'd0);        // Drain
      add_step(ST_IDLE, 16'h0000, 3'd0);
      add_step(ST_IDLE, 16'h0000, 3'd0);
   endtask

   // One clock edge of the model: read before write, then the stage moves
   task automatic model_edge();
      fb_row_t src_row;
      if (drv_rd_en) begin
         exp_row       = model_mem[drv_rd_wl];
         exp_row_known = 1'b1;
      end
      exp_valid = drv_rd_en;
      src_row   = stg_store.sel ? store_row(stg_store) : fill_row(stg_fill);
      for (int i = 0; i < FB_WORDS; i++) begin
         if (stg_fill.wen[i]) begin
            model_mem[stg_fill.wl][i] = src_row[i];
         end
      end
      stg_fill  = drv_fill;
      stg_store = drv_store;
   endtask

   task automatic drive_step(input step_t st);
      fb_fill_in_t  f;
      fb_store_in_t sd;
      logic [31:0]  r;
      logic         wr;
      wr        = (st.kind == ST_FILL) || (st.kind == ST_STORE);
      f.data    = {lcg_next(), lcg_next(), lcg_next(), lcg_next()};
      r         = lcg_next();
      f.ecc     = r[27:0];
      f.wen     = wr ? st.wen : 16'h0000;
      f.wl      = st.wl;
      r         = lcg_next();
      sd.stdecc = {lcg_next(), lcg_next(), r[13:0]};
      sd.sel    = st.sel;
      drv_fill  = f;
      drv_store = sd;
      drv_rd_en = (st.kind == ST_READ);
      drv_rd_wl = st.rd_wl;
      fill_in  <= f;
      store_in <= sd;
      rd_en    <= drv_rd_en;
      rd_wl    <= drv_rd_wl;
   endtask

   task automatic check_row(input fb_row_t got, input fb_row_t exp, input string what);
      if (got !== exp) begin
         $display("FAILED at %0t ns: %s rd_data %h expected %h", $time, what, got, exp);
         $display("test failed");
         $fatal(1, "rd_data mismatch");
      end
   endtask

   task automatic check_valid(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         $display("FAILED at %0t ns: %s rd_valid %b expected %b", $time, what, got, exp);
         $display("test failed");
         $fatal(1, "rd_valid mismatch");
      end
   endtask

   initial begin
      rclk          = 1'b0;
      rst           = 1'b1;
      fill_in       = '0;
      store_in      = '0;
      rd_en         = 1'b0;
      rd_wl         = '0;
      drv_fill      = '0;
      drv_store     = '0;
      drv_rd_en     = 1'b0;
      drv_rd_wl     = '0;
      stg_fill      = '0;
      stg_store     = '0;
      exp_row       = '0;
      exp_valid     = 1'b0;
      exp_row_known = 1'b0;
      lcg_state     = 32'd40;
      build_table();
      cycle_limit = steps.size() + 20;
      repeat (3) @(posedge rclk);
      rst <= 1'b0;
      @(negedge rclk);
      check_valid(rd_valid, 1'b0, "after reset");
      foreach (steps[s]) begin
         @(posedge rclk);
         model_edge();
         drive_step(steps[s]);
         @(negedge rclk);
         check_valid(rd_valid, exp_valid, $sformatf("step %0d", s));
         if (exp_row_known) begin
            check_row(rd_data, exp_row, $sformatf("step %0d", s));
         end
      end
      $display("test passed");
      $finish;
   end

endmodule

`default_nettype wire

/* fb_buf.f */
hdl/fb_types_pkg.sv
hdl/fb_ctrl_pkg.sv
hdl/fb_fill_stage.sv
hdl/fb_store_stage.sv
hdl/fb_data_array.sv
hdl/fb_buf_top.sv
bench/fb_buf_asserts.sv
bench/fb_buf_tb.sv

/* Makefile */
# Verilator lint and simulation of the fill buffer data path

TOP := fb_buf_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f fb_buf.f --top-module $(TOP)
	verilator --lint-only hdl/fb_types_pkg.sv hdl/fb_ctrl_pkg.sv \
		hdl/fb_fill_stage.sv hdl/fb_store_stage.sv hdl/fb_data_array.sv \
		hdl/fb_buf_top.sv --top-module fb_buf_top

# The run passes only if the pass line shows up in the output
sim:
	verilator --binary --timing --assert -f fb_buf.f --top-module $(TOP) -o $(TOP)_sim
	./obj_dir/$(TOP)_sim | tee /dev/stderr | grep '^test passed$$' > /dev/null

clean:
	rm -rf obj_dir
